/* Makefile */
TOP = glbTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module $(TOP) -Mdir obj_dir -f glbBuffer.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test completed successfully"

clean:
	rm -rf obj_dir

/* glbBuffer.f */
+incdir+include
src/glbPkg.sv
src/glbBankSram.sv
src/glbCfgDecode.sv
src/glbBankExec.sv
src/glbPortResult.sv
src/glbTop.sv
testbench/glbTb.sv

/* include/glbBuffer_defs.svh */
// Sizes are fixed at compile time; SRAM_WORD must be a power of two and NUM_PAIR at least two
`ifndef GLB_BUFFER_DEFS_SVH
`define GLB_BUFFER_DEFS_SVH

// ======================================================================
// Base sizes
// ======================================================================
`define GLB_NUM_BANK    8
`define GLB_NUM_PAIR    2
`define GLB_SRAM_WIDTH  16
`define GLB_SRAM_WORD   8
`define GLB_MAXPAR      4
`define GLB_ADDR_WIDTH  8

// ======================================================================
// Derived index widths
// ======================================================================
`define GLB_BANK_W      ($clog2(`GLB_NUM_BANK))
`define GLB_PAIR_W      ($clog2(`GLB_NUM_PAIR))
`define GLB_LANE_W      ($clog2(`GLB_MAXPAR))
// Parallel count holds 0..MAXPAR
`define GLB_PAR_W       ($clog2(`GLB_MAXPAR) + 1)
`define GLB_LINE_W      ($clog2(`GLB_SRAM_WORD))

`endif

/* src/glbBankExec.sv */
// Capacity of the owning pair must be a power of two for the group select to be valid
`timescale 1ns/10ps
`include "glbBuffer_defs.svh"

module glbBankExec (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  glbPkg::bankMapT                         map,
    input  glbPkg::pairPtrT [`GLB_NUM_PAIR-1:0]     pairPtr,
    input  glbPkg::pairCfgT [`GLB_NUM_PAIR-1:0]     pairCfg,
    input  glbPkg::portWordT [`GLB_NUM_PAIR-1:0]    wrPortDat,
    output glbPkg::bankRdT                          bankRd
);

    localparam int AW = `GLB_ADDR_WIDTH;
    localparam int LW = `GLB_LINE_W;
    localparam int SW = `GLB_SRAM_WIDTH;

    glbPkg::pairPtrT    ptr;
    glbPkg::pairCfgT    pcfg;

    logic [AW-1:0]  capMask;
    logic [AW-1:0]  wrGrp;
    logic [AW-1:0]  rdGrp;
    logic           wrEn;
    logic           rdEn;
    logic           rdVldQ;
    logic [LW-1:0]  wrLine;
    logic [LW-1:0]  rdLine;
    logic [SW-1:0]  wrData;
    logic [SW-1:0]  rdData;

    // ==================================================================
    // Own pair selection
    // ==================================================================
    assign ptr  = pairPtr[map.pair];
    assign pcfg = pairCfg[map.pair];

    // Pointer mod capacity, then the group number above the line bits
    assign capMask = pcfg.capacity - 1'b1;
    assign wrGrp   = (ptr.wrPtr & capMask) >> LW;
    assign rdGrp   = (ptr.rdPtr & capMask) >> LW;

    // ==================================================================
    // Write and read issue
    // ==================================================================
    assign wrEn   = map.en && ptr.wrFire && (wrGrp == AW'(map.relIdx));
    assign wrLine = ptr.wrPtr[LW-1:0];
    // This bank holds one lane of the word
    assign wrData = wrPortDat[map.pair].lane[map.parIdx];

    assign rdEn   = map.en && ptr.rdFire && (rdGrp == AW'(map.relIdx));
    assign rdLine = ptr.rdPtr[LW-1:0];

    glbBankSram #(
        .WIDTH  (SW),
        .DEPTH  (`GLB_SRAM_WORD)
    ) uSram (
        .clk    (clk),
        .wrEn   (wrEn),
        .wrAddr (wrLine),
        .wrData (wrData),
        .rdEn   (rdEn),
        .rdAddr (rdLine),
        .rdData (rdData)
    );

    // Valid lines up with the registered SRAM output
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdVldQ <= 1'b0;
        end else begin
            rdVldQ <= rdEn;
        end
    end

    assign bankRd = '{vld: rdVldQ, dat: rdData};

endmodule

/* src/glbBankSram.sv */
// Registered read with old data on a same-line collision; contents are undefined after power-up
`timescale 1ns/10ps
`include "glbBuffer_defs.svh"

module glbBankSram #(
    parameter int WIDTH = `GLB_SRAM_WIDTH,
    parameter int DEPTH = `GLB_SRAM_WORD
) (
    input  logic                        clk,
    input  logic                        wrEn,
    input  logic [$clog2(DEPTH)-1:0]    wrAddr,
    input  logic [WIDTH-1:0]            wrData,
    input  logic                        rdEn,
    input  logic [$clog2(DEPTH)-1:0]    rdAddr,
    output logic [WIDTH-1:0]            rdData
);

    logic [WIDTH-1:0] mem [DEPTH];

    // Write port
    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // Read port holds its output between reads
    always_ff @(posedge clk) begin
        if (rdEn) begin
            rdData <= mem[rdAddr];
        end
    end

endmodule

/* src/glbCfgDecode.sv */
// Bank counts per pair are expected to be multiples of the parallel count; a count of 0 acts as 1
`timescale 1ns/10ps
`include "glbBuffer_defs.svh"

module glbCfgDecode (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    cfgVld,
    input  glbPkg::cfgReqT                          cfg,
    output glbPkg::bankMapT [`GLB_NUM_BANK-1:0]     bankMap,
    output glbPkg::pairCfgT [`GLB_NUM_PAIR-1:0]     pairCfg,
    output logic                                    cfgApply
);

    localparam int AW  = `GLB_ADDR_WIDTH;
    localparam int LW  = `GLB_LINE_W;
    localparam int BW  = `GLB_BANK_W;
    localparam int LNW = `GLB_LANE_W;

    // Running lane and group counters, one per pair
    logic [`GLB_PAR_W-1:0]  parRun [`GLB_NUM_PAIR];
    logic [BW:0]            grpRun [`GLB_NUM_PAIR];

    glbPkg::bankMapT [`GLB_NUM_BANK-1:0] bankMapNxt;
    glbPkg::pairCfgT [`GLB_NUM_PAIR-1:0] pairCfgNxt;

    // ==================================================================
    // Map decode
    // ==================================================================

    // Banks are ranked by ascending index inside their pair
    always_comb begin
        for (int p = 0; p < `GLB_NUM_PAIR; p++) begin
            parRun[p] = '0;
            grpRun[p] = '0;
        end
        for (int b = 0; b < `GLB_NUM_BANK; b++) begin
            bankMapNxt[b] = '0;
            if (cfg.bankEn[b]) begin
                bankMapNxt[b].en     = 1'b1;
                bankMapNxt[b].pair   = cfg.bankPair[b];
                bankMapNxt[b].parIdx = parRun[cfg.bankPair[b]][LNW-1:0];
                bankMapNxt[b].relIdx = grpRun[cfg.bankPair[b]][BW-1:0];
                // Lane wraps at the parallel count, then the next group starts
                if (parRun[cfg.bankPair[b]] + 1'b1 >= cfg.parCnt[cfg.bankPair[b]]) begin
                    parRun[cfg.bankPair[b]] = '0;
                    grpRun[cfg.bankPair[b]] = grpRun[cfg.bankPair[b]] + 1'b1;
                end else begin
                    parRun[cfg.bankPair[b]] = parRun[cfg.bankPair[b]] + 1'b1;
                end
            end
        end
        // Capacity is whole groups times the bank depth
        for (int p = 0; p < `GLB_NUM_PAIR; p++) begin
            pairCfgNxt[p].parCnt   = cfg.parCnt[p];
            pairCfgNxt[p].capacity = AW'(grpRun[p]) << LW;
        end
    end

    // ==================================================================
    // Map registers
    // ==================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bankMap  <= '0;
            pairCfg  <= '0;
            cfgApply <= 1'b0;
        end else begin
            cfgApply <= cfgVld;
            if (cfgVld) begin
                bankMap <= bankMapNxt;
                pairCfg <= pairCfgNxt;
            end
        end
    end

endmodule

/* src/glbPkg.sv */
// Shared packed types; all widths follow the sizes in glbBuffer_defs.svh
`include "glbBuffer_defs.svh"

package glbPkg;

    // ==================================================================
    // Configuration
    // ==================================================================

    // Bank enables and owners, plus parallel bank count per pair
    typedef struct packed {
        logic [`GLB_NUM_BANK-1:0]                   bankEn;
        logic [`GLB_NUM_BANK-1:0][`GLB_PAIR_W-1:0]  bankPair;
        logic [`GLB_NUM_PAIR-1:0][`GLB_PAR_W-1:0]   parCnt;
    } cfgReqT;

    // Decoded entry of one bank
    typedef struct packed {
        logic                       en;
        logic [`GLB_PAIR_W-1:0]     pair;
        logic [`GLB_LANE_W-1:0]     parIdx;
        logic [`GLB_BANK_W-1:0]     relIdx;
    } bankMapT;

    // Parallel count and capacity in words of one pair
    typedef struct packed {
        logic [`GLB_PAR_W-1:0]      parCnt;
        logic [`GLB_ADDR_WIDTH-1:0] capacity;
    } pairCfgT;

    // ==================================================================
    // Datapath
    // ==================================================================

    // Pointers and fire strobes sent from the result stage to the banks
    typedef struct packed {
        logic [`GLB_ADDR_WIDTH-1:0] wrPtr;
        logic [`GLB_ADDR_WIDTH-1:0] rdPtr;
        logic                       wrFire;
        logic                       rdFire;
    } pairPtrT;

    typedef struct packed {
        logic                       vld;
        logic [`GLB_SRAM_WIDTH-1:0] dat;
    } bankRdT;

    typedef struct packed {
        logic [`GLB_MAXPAR-1:0][`GLB_SRAM_WIDTH-1:0] lane;
    } portWordT;

endpackage

/* src/glbPortResult.sv */
// Writes to a pair with no banks advance its pointer; configure before use
`timescale 1ns/10ps
`include "glbBuffer_defs.svh"

module glbPortResult (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        cfgApply,
    input  glbPkg::bankMapT [`GLB_NUM_BANK-1:0]         bankMap,
    input  glbPkg::pairCfgT [`GLB_NUM_PAIR-1:0]         pairCfg,
    input  glbPkg::bankRdT [`GLB_NUM_BANK-1:0]          bankRd,
    input  logic [`GLB_NUM_PAIR-1:0]                    wrPortDatVld,
    input  logic [`GLB_NUM_PAIR-1:0]                    rdPortReq,
    output glbPkg::pairPtrT [`GLB_NUM_PAIR-1:0]         pairPtr,
    output logic [`GLB_NUM_PAIR-1:0]                    wrPortDatRdy,
    output glbPkg::portWordT [`GLB_NUM_PAIR-1:0]        rdPortDat,
    output logic [`GLB_NUM_PAIR-1:0]                    rdPortDatVld,
    output logic [`GLB_NUM_PAIR-1:0]                    portFull,
    output logic [`GLB_NUM_PAIR-1:0]                    portEmpty,
    output logic [`GLB_NUM_PAIR-1:0][`GLB_ADDR_WIDTH-1:0] wrPortReqNum,
    output logic [`GLB_NUM_PAIR-1:0][`GLB_ADDR_WIDTH-1:0] rdPortReqNum
);

    localparam int AW = `GLB_ADDR_WIDTH;
    localparam int PW = `GLB_PAIR_W;

    for (genvar p = 0; p < `GLB_NUM_PAIR; p++) begin : gPair
        logic [AW-1:0]      wrPtrQ;
        logic [AW-1:0]      rdPtrQ;
        logic [AW-1:0]      wrBase;
        logic [AW-1:0]      rdBase;
        logic [AW-1:0]      used;
        logic               full;
        logic               empty;
        logic               wrFire;
        logic               rdFire;
        glbPkg::portWordT   gathered;
        logic               gatherVld;

        // ==============================================================
        // Pointers and flags
        // ==============================================================

        // A new map is served from zero in the very cycle it takes effect
        assign wrBase = cfgApply ? '0 : wrPtrQ;
        assign rdBase = cfgApply ? '0 : rdPtrQ;

        assign used  = wrBase - rdBase;
        assign empty = (wrBase == rdBase);
        // Not empty keeps a zero-capacity pair from reading as full
        assign full  = !empty && (used == pairCfg[p].capacity);

        assign wrFire = wrPortDatVld[p] && !full;
        assign rdFire = rdPortReq[p] && !empty;

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                wrPtrQ <= '0;
                rdPtrQ <= '0;
            end else begin
                wrPtrQ <= wrBase + {{(AW-1){1'b0}}, wrFire};
                rdPtrQ <= rdBase + {{(AW-1){1'b0}}, rdFire};
            end
        end

        assign pairPtr[p] = '{wrPtr: wrBase, rdPtr: rdBase, wrFire: wrFire, rdFire: rdFire};

        assign wrPortDatRdy[p] = !full;
        assign portFull[p]     = full;
        assign portEmpty[p]    = empty;
        assign wrPortReqNum[p] = pairCfg[p].capacity - used;
        assign rdPortReqNum[p] = used;

        // ==============================================================
        // Read data gathering
        // ==============================================================

        // Lanes without a returning bank stay zero
        always_comb begin
            gathered  = '0;
            gatherVld = 1'b0;
            for (int b = 0; b < `GLB_NUM_BANK; b++) begin
                if (bankMap[b].en && (bankMap[b].pair == PW'(p)) && bankRd[b].vld) begin
                    gathered.lane[bankMap[b].parIdx] = bankRd[b].dat;
                    gatherVld = 1'b1;
                end
            end
        end

        assign rdPortDat[p]    = gathered;
        assign rdPortDatVld[p] = gatherVld;
    end

endmodule

/* src/glbTop.sv */
// Read data follows an accepted request by one cycle and has no back-pressure
`timescale 1ns/10ps
`include "glbBuffer_defs.svh"

module glbTop (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        cfgVld,
    input  glbPkg::cfgReqT                              cfg,
    input  glbPkg::portWordT [`GLB_NUM_PAIR-1:0]        wrPortDat,
    input  logic [`GLB_NUM_PAIR-1:0]                    wrPortDatVld,
    input  logic [`GLB_NUM_PAIR-1:0]                    rdPortReq,
    output logic [`GLB_NUM_PAIR-1:0]                    wrPortDatRdy,
    output glbPkg::portWordT [`GLB_NUM_PAIR-1:0]        rdPortDat,
    output logic [`GLB_NUM_PAIR-1:0]                    rdPortDatVld,
    output logic [`GLB_NUM_PAIR-1:0]                    portFull,
    output logic [`GLB_NUM_PAIR-1:0]                    portEmpty,
    output logic [`GLB_NUM_PAIR-1:0][`GLB_ADDR_WIDTH-1:0] wrPortReqNum,
    output logic [`GLB_NUM_PAIR-1:0][`GLB_ADDR_WIDTH-1:0] rdPortReqNum
);

    glbPkg::bankMapT [`GLB_NUM_BANK-1:0]    bankMap;
    glbPkg::pairCfgT [`GLB_NUM_PAIR-1:0]    pairCfg;
    glbPkg::pairPtrT [`GLB_NUM_PAIR-1:0]    pairPtr;
    glbPkg::bankRdT [`GLB_NUM_BANK-1:0]     bankRd;
    logic                                   cfgApply;

    // ==================================================================
    // Configuration decode
    // ==================================================================
    glbCfgDecode uDecode (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfgVld     (cfgVld),
        .cfg        (cfg),
        .bankMap    (bankMap),
        .pairCfg    (pairCfg),
        .cfgApply   (cfgApply)
    );

    // ==================================================================
    // Banks
    // ==================================================================
    for (genvar b = 0; b < `GLB_NUM_BANK; b++) begin : gBank
        glbBankExec uExec (
            .clk        (clk),
            .rst_n      (rst_n),
            .map        (bankMap[b]),
            .pairPtr    (pairPtr),
            .pairCfg    (pairCfg),
            .wrPortDat  (wrPortDat),
            .bankRd     (bankRd[b])
        );
    end

    // Pointers, flags and read word assembly
    glbPortResult uResult (
        .clk            (clk),
        .rst_n          (rst_n),
        .cfgApply       (cfgApply),
        .bankMap        (bankMap),
        .pairCfg        (pairCfg),
        .bankRd         (bankRd),
        .wrPortDatVld   (wrPortDatVld),
        .rdPortReq      (rdPortReq),
        .pairPtr        (pairPtr),
        .wrPortDatRdy   (wrPortDatRdy),
        .rdPortDat      (rdPortDat),
        .rdPortDatVld   (rdPortDatVld),
        .portFull       (portFull),
        .portEmpty      (portEmpty),
        .wrPortReqNum   (wrPortReqNum),
        .rdPortReqNum   (rdPortReqNum)
    );

endmodule

/* testbench/glbTb.sv */
// Checks are off during reset; traffic stays idle around each configuration pulse
`timescale 1ns/10ps
`include "glbBuffer_defs.svh"

module glbTb;

    localparam int CLK_PERIOD   = 40;
    // Test lengths below add up to about 180 cycles
    localparam int TEST_CYCLES  = 200;
    localparam int WATCH_CYCLES = TEST_CYCLES + 100;
    localparam int NP           = `GLB_NUM_PAIR;
    localparam int AW           = `GLB_ADDR_WIDTH;

    logic                       clk;
    logic                       rst_n;
    logic                       cfgVld;
    glbPkg::cfgReqT             cfg;
    glbPkg::portWordT [NP-1:0]  wrPortDat;
    logic [NP-1:0]              wrPortDatVld;
    logic [NP-1:0]              rdPortReq;
    logic [NP-1:0]              wrPortDatRdy;
    glbPkg::portWordT [NP-1:0]  rdPortDat;
    logic [NP-1:0]              rdPortDatVld;
    logic [NP-1:0]              portFull;
    logic [NP-1:0]              portEmpty;
    logic [NP-1:0][AW-1:0]      wrPortReqNum;
    logic [NP-1:0][AW-1:0]      rdPortReqNum;

    // Reference model state
    glbPkg::portWordT           modelQ [NP][$];
    glbPkg::portWordT           popped;
    int                         modelCnt [NP];
    int                         modelCap [NP];
    int                         modelPar [NP];
    logic [NP-1:0]              expRdVld;
    glbPkg::portWordT [NP-1:0]  expRdDat;
    logic [NP-1:0]              expEmpty;
    logic [NP-1:0]              expFull;
    logic [NP-1:0][AW-1:0]      expWrNum;
    logic [NP-1:0][AW-1:0]      expRdNum;
    logic [NP-1:0][AW-1:0]      expCap;

    int                         seed;
    int                         errCnt;
    int                         testCnt;
    glbPkg::cfgReqT             cfgA;
    glbPkg::cfgReqT             cfgB;

    glbTop dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCH_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the run did not finish", WATCH_CYCLES);
        $display("Test failed");
        $finish;
    end

    // ==================================================================
    // Reference model
    // ==================================================================

    // Capacity = (banks of the pair / parallel count) groups of SRAM_WORD lines
    function automatic int capacityOf(glbPkg::cfgReqT c, int p);
        int n;
        n = 0;
        for (int b = 0; b < `GLB_NUM_BANK; b++) begin
            if (c.bankEn[b] && int'(c.bankPair[b]) == p) n++;
        end
        if (c.parCnt[p] == '0) return 0;
        return (n / int'(c.parCnt[p])) * `GLB_SRAM_WORD;
    endfunction

    // Lanes at or above the parallel count have no bank and read back zero
    function automatic glbPkg::portWordT maskLanes(glbPkg::portWordT w, int par);
        glbPkg::portWordT m;
        m = w;
        for (int l = 0; l < `GLB_MAXPAR; l++) begin
            if (l >= par) m.lane[l] = '0;
        end
        return m;
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int p = 0; p < NP; p++) begin
                modelQ[p].delete();
                modelCnt[p] <= 0;
                modelCap[p] <= 0;
                modelPar[p] <= 0;
            end
            expRdVld <= '0;
            expRdDat <= '0;
        end else begin
            for (int p = 0; p < NP; p++) begin
                expRdVld[p] <= 1'b0;
                if (cfgVld) begin
                    // New map takes effect on this edge with both pointers at zero
                    modelQ[p].delete();
                    modelCap[p] <= capacityOf(cfg, p);
                    modelPar[p] <= int'(cfg.parCnt[p]);
                end else begin
                    if (rdPortReq[p] && !expEmpty[p]) begin
                        popped = modelQ[p].pop_front();
                        expRdDat[p] <= popped;
                        expRdVld[p] <= 1'b1;
                    end
                    if (wrPortDatVld[p] && !expFull[p]) begin
                        modelQ[p].push_back(maskLanes(wrPortDat[p], modelPar[p]));
                    end
                end
                modelCnt[p] <= modelQ[p].size();
            end
        end
    end

    always_comb begin
        for (int p = 0; p < NP; p++) begin
            expEmpty[p] = (modelCnt[p] == 0);
            expFull[p]  = (modelCnt[p] != 0) && (modelCnt[p] == modelCap[p]);
            expCap[p]   = AW'(modelCap[p]);
            expWrNum[p] = AW'(modelCap[p] - modelCnt[p]);
            expRdNum[p] = AW'(modelCnt[p]);
        end
    end

    // ==================================================================
    // Checks
    // ==================================================================
    function automatic void reportMismatch(string sig, int p, logic [63:0] got,
                                           logic [63:0] want);
        $display("error t=%0t %s[%0d] got %0h expected %0h", $time, sig, p, got, want);
        errCnt++;
    endfunction

    function automatic void reportFailure(string msg);
        $display("Failure at t=%0t: %s", $time, msg);
        errCnt++;
    endfunction

    for (genvar p = 0; p < NP; p++) begin : gCheck
        aEmpty: assert property (@(posedge clk) disable iff (!rst_n)
            portEmpty[p] == expEmpty[p])
            else reportMismatch("portEmpty", p, 64'($sampled(portEmpty[p])),
                                64'($sampled(expEmpty[p])));
        aFull: assert property (@(posedge clk) disable iff (!rst_n)
            portFull[p] == expFull[p])
            else reportMismatch("portFull", p, 64'($sampled(portFull[p])),
                                64'($sampled(expFull[p])));
        aRdy: assert property (@(posedge clk) disable iff (!rst_n)
            wrPortDatRdy[p] == !expFull[p])
            else reportMismatch("wrPortDatRdy", p, 64'($sampled(wrPortDatRdy[p])),
                                64'($sampled(!expFull[p])));
        aWrNum: assert property (@(posedge clk) disable iff (!rst_n)
            wrPortReqNum[p] == expWrNum[p])
            else reportMismatch("wrPortReqNum", p, 64'($sampled(wrPortReqNum[p])),
                                64'($sampled(expWrNum[p])));
        aRdNum: assert property (@(posedge clk) disable iff (!rst_n)
            rdPortReqNum[p] == expRdNum[p])
            else reportMismatch("rdPortReqNum", p, 64'($sampled(rdPortReqNum[p])),
                                64'($sampled(expRdNum[p])));
        // Free space and occupancy always add up to the capacity
        aSum: assert property (@(posedge clk) disable iff (!rst_n)
            wrPortReqNum[p] + rdPortReqNum[p] == expCap[p])
            else reportMismatch("wrPortReqNum+rdPortReqNum", p,
                                64'($sampled(wrPortReqNum[p] + rdPortReqNum[p])),
                                64'($sampled(expCap[p])));
        aVld: assert property (@(posedge clk) disable iff (!rst_n)
            rdPortDatVld[p] == expRdVld[p])
            else reportMismatch("rdPortDatVld", p, 64'($sampled(rdPortDatVld[p])),
                                64'($sampled(expRdVld[p])));
        aDat: assert property (@(posedge clk) disable iff (!rst_n)
            expRdVld[p] |-> rdPortDat[p] == expRdDat[p])
            else reportMismatch("rdPortDat", p, 64'($sampled(rdPortDat[p])),
                                64'($sampled(expRdDat[p])));
        aLatency: assert property (@(posedge clk) disable iff (!rst_n)
            (rdPortReq[p] && !portEmpty[p]) |=> rdPortDatVld[p])
            else reportFailure($sformatf(
                "pair %0d gave no read data one cycle after an accepted request", p));
        aEmptyReq: assert property (@(posedge clk) disable iff (!rst_n)
            (rdPortReq[p] && portEmpty[p]) |=> !rdPortDatVld[p])
            else reportFailure($sformatf(
                "pair %0d returned data for a request while empty", p));
    end

    // ==================================================================
    // Stimulus
    // ==================================================================
    function glbPkg::portWordT randWord();
        randWord = {$random(seed), $random(seed)};
    endfunction

    // All tasks start and end right after a rising edge
    task pushWord(input int p, input glbPkg::portWordT w);
        int waitCnt;
        waitCnt = 0;
        wrPortDat[p]    <= w;
        wrPortDatVld[p] <= 1'b1;
        @(negedge clk);
        while (!wrPortDatRdy[p] && waitCnt < 40) begin
            @(negedge clk);
            waitCnt++;
        end
        if (!wrPortDatRdy[p]) reportFailure($sformatf("pair %0d write never accepted", p));
        @(posedge clk);
        wrPortDatVld[p] <= 1'b0;
    endtask

    task pushRandom(input int p, input int n);
        repeat (n) pushWord(p, randWord());
    endtask

    task writeWhileFull(input int p);
        wrPortDat[p]    <= randWord();
        wrPortDatVld[p] <= 1'b1;
        repeat (3) @(posedge clk);
        wrPortDatVld[p] <= 1'b0;
    endtask

    // Back-to-back requests and time for the last data to return
    task requestReads(input int p, input int n);
        rdPortReq[p] <= 1'b1;
        repeat (n) @(posedge clk);
        rdPortReq[p] <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    task applyCfg(input glbPkg::cfgReqT c);
        cfg    <= c;
        cfgVld <= 1'b1;
        @(posedge clk);
        cfgVld <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    task finishTest(input string name);
        testCnt++;
        $display("test %0d %s finished, %0d errors so far", testCnt, name, errCnt);
    endtask

    initial begin
        seed         = 32'habb1406d;
        errCnt       = 0;
        testCnt      = 0;
        rst_n        = 1'b0;
        cfgVld       = 1'b0;
        cfg          = '0;
        wrPortDat    = '0;
        wrPortDatVld = '0;
        rdPortReq    = '0;
        // Pair 0 on even banks at 2 wide, pair 1 on odd banks at 4 wide
        cfgA.bankEn   = 8'hFF;
        cfgA.bankPair = 8'hAA;
        cfgA.parCnt   = {3'd4, 3'd2};
        // Pair 0 on banks 0 and 7 at 1 wide, pair 1 on banks 1 to 6 at 3 wide
        cfgB.bankEn   = 8'hFF;
        cfgB.bankPair = 8'h7E;
        cfgB.parCnt   = {3'd3, 3'd1};
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        repeat (4) @(posedge clk);
        finishTest("reset state");

        applyCfg(cfgA);
        for (int i = 0; i < 6; i++) begin
            pushWord(0, randWord());
            pushWord(1, randWord());
        end
        requestReads(0, 6);
        requestReads(1, 6);
        finishTest("write and read back");

        pushRandom(1, 5);
        requestReads(1, 5);
        finishTest("back-to-back reads");

        pushRandom(0, 16);
        writeWhileFull(0);
        pushRandom(1, 8);
        writeWhileFull(1);
        requestReads(0, 16);
        requestReads(1, 8);
        finishTest("fill to capacity");

        requestReads(0, 3);
        // Same-cycle write and read where the first read meets an empty pair
        for (int i = 0; i < 6; i++) begin
            wrPortDat[1]    <= randWord();
            wrPortDatVld[1] <= 1'b1;
            rdPortReq[1]    <= 1'b1;
            @(posedge clk);
        end
        wrPortDatVld[1] <= 1'b0;
        rdPortReq[1]    <= 1'b0;
        requestReads(1, 2);
        finishTest("counts and empty requests");

        pushRandom(0, 3);
        pushRandom(1, 2);
        applyCfg(cfgB);
        for (int i = 0; i < 10; i++) begin
            pushWord(0, randWord());
            pushWord(1, randWord());
        end
        requestReads(0, 10);
        requestReads(1, 10);
        finishTest("reconfiguration");

        repeat (3) @(posedge clk);
        $display("Summary: %0d tests run, %0d checks failed", testCnt, errCnt);
        if (errCnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
